// File: dv/tb_uart_link.sv
`include "uart_settings.svh"

module tb_uart_link;
    timeunit 1ns;
    timeprecision 1ps;
    import uart_pkg::*;

    localparam int N = `UART_CLKS_PER_BIT;                 // Cycles per bit
    localparam int FRAME_BITS = 11;

    typedef struct packed {
        logic       inject;                                // Testbench drives rx
        uart_byte_t data;
        logic       flip;                                  // Invert parity bit
        logic       stop;                                  // Stop bit value
        logic       false_start;                           // Glitch before frame
        uart_byte_t exp_data;
        rx_status_t exp_status;
    } record_t;

    logic       baud_clk;
    logic       rst_n;
    uart_byte_t tx_data;
    logic       start_tx;
    logic       tx;
    logic       tx_busy;
    logic       rx;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       parity_err;
    logic       frame_err;
    logic       loop_mode;                                 // 1 routes tx to rx
    logic       inj_bit;                                   // Serialized line level
    record_t    recs[$];
    integer     seed;
    int         cycle_cnt;
    int         cycle_limit;                               // Zero until records known
    int         got_cnt;                                   // rx_valid pulses seen
    uart_byte_t got_data;
    rx_status_t got_status;

    assign rx = loop_mode ? tx : inj_bit;

    uart_link u_uart_link (
        .baud_clk   (baud_clk),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .start_tx   (start_tx),
        .tx         (tx),
        .tx_busy    (tx_busy),
        .rx         (rx),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .parity_err (parity_err),
        .frame_err  (frame_err)
    );

    always #5 baud_clk = ~baud_clk;

    always @(posedge baud_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // Parity bit from the count of ones in the byte
    function automatic logic parity_of(input uart_byte_t d);
        int ones;
        ones = 0;
        for (int b = 0; b < 8; b++) begin
            ones = ones + d[b];
        end
        // Odd count needs a 1 for even parity
        return ((ones % 2) == 1) ^ (`UART_PARITY_ODD != 0);
    endfunction

    // Advance to the next falling edge and log any received byte
    task automatic step_cycle();
        @(negedge baud_clk);
        if (rx_valid) begin
            got_cnt    = got_cnt + 1;
            got_data   = rx_data;
            got_status = '{parity_err: parity_err, frame_err: frame_err};
        end
    endtask

    task automatic check_byte(input string what, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %02h expected %02h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_status(input string what, input rx_status_t got, input rx_status_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got parity_err=%0b frame_err=%0b expected %0b %0b",
                     $time, what, got.parity_err, got.frame_err,
                     exp.parity_err, exp.frame_err);
            $display("Test FAILED");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %0b expected %0b", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "level mismatch");
        end
    endtask

    task automatic wait_rx_valid(input int base);
        while (got_cnt == base) begin
            step_cycle();                                  // Bounded by cycle_limit
        end
    endtask

    task automatic load_records();
        int      fd;
        int      n;
        int      d, fl, st, fs, ed, ep, ef;
        string   line;
        string   mode;
        record_t r;
        fd = $fopen("dv/uart_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the data file dv/uart_input.txt");
            $display("Test FAILED");
            $fatal(1, "no data file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                                mode, d, fl, st, fs, ed, ep, ef);
                    if (n != 8) begin
                        $display("Malformed record in data file: %s", line);
                        $display("Test FAILED");
                        $fatal(1, "bad record");
                    end else begin
                        r.inject                = (mode == "I");
                        r.data                  = d[7:0];
                        r.flip                  = fl[0];
                        r.stop                  = st[0];
                        r.false_start           = fs[0];
                        r.exp_data              = ed[7:0];
                        r.exp_status.parity_err = ep[0];
                        r.exp_status.frame_err  = ef[0];
                        recs.push_back(r);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Send through the DUT transmitter and watch the line bit by bit
    task automatic send_loopback(input record_t r);
        logic [10:0] bits;
        int          base;
        int          k;
        bits      = {1'b1, parity_of(r.data), r.data, 1'b0};
        base      = got_cnt;
        loop_mode = 1'b1;
        tx_data   = r.data;
        start_tx  = 1'b1;
        step_cycle();                                      // Accept edge
        start_tx  = 1'b0;
        tx_data   = ~r.data;                               // Byte already captured
        for (k = 0; k <= FRAME_BITS * N; k++) begin
            check_level("tx_busy", tx_busy, k < FRAME_BITS * N);
            check_level("tx", tx, (k < FRAME_BITS * N) ? bits[k / N] : 1'b1);
            start_tx = (k == 3 * N);                       // Must be dropped while busy
            if (k < FRAME_BITS * N) begin
                step_cycle();
            end
        end
        wait_rx_valid(base);
        repeat (N) begin
            step_cycle();
            check_level("tx_busy after frame", tx_busy, 1'b0);
        end
        check_byte("rx_data loopback", got_data, r.exp_data);
        check_status("rx flags loopback", got_status, r.exp_status);
    endtask

    task automatic send_inject(input record_t r);
        logic [10:0] bits;
        int          base;
        int          i;
        bits      = {r.stop, parity_of(r.data) ^ r.flip, r.data, 1'b0};
        loop_mode = 1'b0;
        inj_bit   = 1'b1;
        repeat (N) step_cycle();                           // Idle high before the frame
        if (r.false_start) begin
            inj_bit = 1'b0;                                // Quarter bit glitch
            repeat (N / 4) step_cycle();
            inj_bit = 1'b1;
            // A start taken here would strobe within one frame time
            repeat (FRAME_BITS * N) begin
                step_cycle();
                check_level("rx_valid after glitch", rx_valid, 1'b0);
            end
        end
        base = got_cnt;
        for (i = 0; i < FRAME_BITS; i++) begin
            inj_bit = bits[i];                             // Wire order from bit 0
            repeat (N) step_cycle();
        end
        inj_bit = 1'b1;
        wait_rx_valid(base);
        check_byte("rx_data inject", got_data, r.exp_data);
        check_status("rx flags inject", got_status, r.exp_status);
    endtask

    initial begin
        int gap;
        baud_clk    = 1'b0;
        rst_n       = 1'b0;
        tx_data     = '0;
        start_tx    = 1'b0;
        loop_mode   = 1'b1;
        inj_bit     = 1'b1;
        seed        = 32'h3d82_fd8b;
        cycle_cnt   = 0;
        cycle_limit = 0;
        got_cnt     = 0;
        got_data    = '0;
        got_status  = '0;
        load_records();
        cycle_limit = (recs.size() + 2) * FRAME_BITS * N * 2;
        repeat (10) step_cycle();
        rst_n = 1'b1;
        step_cycle();
        check_level("tx after reset", tx, 1'b1);
        check_level("tx_busy after reset", tx_busy, 1'b0);
        check_level("rx_valid after reset", rx_valid, 1'b0);
        foreach (recs[i]) begin
            if (recs[i].inject) begin
                send_inject(recs[i]);
            end else begin
                send_loopback(recs[i]);
            end
            gap = $unsigned($random(seed)) % 16;           // Idle line between frames
            repeat (gap) step_cycle();
        end
        if (got_cnt == recs.size()) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Received %0d bytes for %0d records", got_cnt, recs.size());
            $display("Test FAILED");
            $fatal(1, "byte count mismatch");
        end
    end

endmodule

// File: dv/uart_input.txt
# mode data flip stop false_start exp_data exp_parity_err exp_frame_err
# L loops tx back to rx and I sends a frame serialized by the testbench
L 00 0 1 0 00 0 0
L FF 0 1 0 FF 0 0
L 55 0 1 0 55 0 0
L AA 0 1 0 AA 0 0
L 3C 0 1 0 3C 0 0
L 81 0 1 0 81 0 0
I A5 1 1 0 A5 1 0
I 5A 0 0 0 5A 0 1
I C3 0 1 1 C3 0 0
L 01 0 1 0 01 0 0
I 7E 1 0 0 7E 1 1
I 10 0 1 0 10 0 0
L 7F 0 1 0 7F 0 0
I 80 1 1 1 80 1 0
L E7 0 1 0 E7 0 0
I FF 0 0 0 FF 0 1
L 96 0 1 0 96 0 0
I 00 1 1 0 00 1 0

// File: dv/uart_link_sva.sv
`include "uart_settings.svh"

module uart_link_sva (
    input logic baud_clk,
    input logic rst_n,
    input logic tx,
    input logic tx_busy,
    input logic rx_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CLKS = 11 * `UART_CLKS_PER_BIT;           // One whole frame
    localparam int LEN_W = $clog2(FRAME_CLKS + 1);
    localparam logic [LEN_W-1:0] LEN_FULL = LEN_W'(FRAME_CLKS);

    logic [LEN_W-1:0] busy_len;                                   // Cycles seen busy

    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            busy_len <= '0;
        end else if (tx_busy) begin
            busy_len <= busy_len + LEN_W'(1);
        end else begin
            busy_len <= '0;                                       // Idle clears the run
        end
    end

    // Line idles high between frames
    a_tx_idle_high: assert property (@(posedge baud_clk) disable iff (!rst_n)
        !tx_busy |-> tx) else $error("tx low while tx_busy is low");

    a_rx_valid_pulse: assert property (@(posedge baud_clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid) else $error("rx_valid high on two cycles");

    // Busy never outlasts a frame
    a_busy_max: assert property (@(posedge baud_clk) disable iff (!rst_n)
        tx_busy |-> busy_len < LEN_FULL) else $error("tx_busy longer than a frame");

    a_busy_len: assert property (@(posedge baud_clk) disable iff (!rst_n)
        $fell(tx_busy) |-> busy_len == LEN_FULL) else $error("tx_busy shorter than a frame");

endmodule

bind uart_link uart_link_sva u_sva (.*);

// File: list.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/shift_if.sv
verilog/bit_tick_gen.sv
verilog/piso_shifter.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_link.sv
dv/uart_link_sva.sv
dv/tb_uart_link.sv

// File: run.sh
#!/bin/sh
# Build and run the uart_link testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f list.f --top-module tb_uart_link -o sim_uart_link
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_uart_link
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi
exit 0

// File: verilog/bit_tick_gen.sv
`include "uart_settings.svh"

module bit_tick_gen (
    input  logic baud_clk,
    input  logic rst_n,
    input  logic restart,                              // Realign to a bit start
    output logic mid_tick,                             // Middle of the bit
    output logic end_tick                              // Last cycle of the bit
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

    logic [CNT_W-1:0] cnt;                             // Cycle position in the bit

    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (restart) begin
            cnt <= '0;                                 // Frame start realigns
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;                                 // Wrap into next bit
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Single cycle decodes of the count
    assign mid_tick = (cnt == CNT_MID);
    assign end_tick = (cnt == CNT_LAST);

endmodule

// File: verilog/piso_shifter.sv
module piso_shifter (
    input  logic      baud_clk,
    input  logic      rst_n,
    shift_if.shifter  sh
);
    import uart_pkg::*;

    uart_frame_t sr;                                   // Frame in flight

    // Load wins over shift
    // Ones fill from the top so the line returns high
    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            sr <= '1;                                  // Idle line is high
        end else if (sh.load) begin
            sr <= sh.frame;                            // Start bit lands in bit 0
        end else if (sh.shift) begin
            sr <= {1'b1, sr[$bits(uart_frame_t)-1:1]};
        end
    end

    assign sh.serial = sr[0];                          // Wire sees the LSB

endmodule

// File: verilog/shift_if.sv
// Control side and register side of the transmit shifter
interface shift_if;
    import uart_pkg::*;

    logic        load;                                 // Take a whole frame
    logic        shift;                                // Move one bit right
    uart_frame_t frame;                                // Parallel frame in
    logic        serial;                               // Register bit zero

    modport ctrl (
        output load,
        output shift,
        output frame
    );

    modport shifter (
        input  load,
        input  shift,
        input  frame,
        output serial
    );

endinterface

// File: verilog/uart_link.sv
module uart_link (
    input  logic       baud_clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,                        // Byte to send
    input  logic       start_tx,                       // Send request pulse
    output logic       tx,                             // Serial line out
    output logic       tx_busy,                        // Frame in progress
    input  logic       rx,                             // Serial line in
    output logic [7:0] rx_data,                        // Received byte
    output logic       rx_valid,                       // Byte strobe
    output logic       parity_err,                     // Parity mismatch
    output logic       frame_err                       // Low stop bit
);
    import uart_pkg::*;

    rx_status_t rx_status;                             // Both receive flags

    // Transmit control to frame register
    shift_if u_sh ();

    uart_tx u_tx (
        .baud_clk (baud_clk),
        .rst_n    (rst_n),
        .tx_data  (tx_data),
        .start_tx (start_tx),
        .tx_busy  (tx_busy),
        .sh       (u_sh.ctrl)
    );

    piso_shifter u_shifter (
        .baud_clk (baud_clk),
        .rst_n    (rst_n),
        .sh       (u_sh.shifter)
    );

    assign tx = u_sh.serial;                           // Register LSB drives line

    // Receive side is independent of transmit
    uart_rx u_rx (
        .baud_clk  (baud_clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_status (rx_status)
    );

    // Split the status struct onto flag pins
    assign parity_err = rx_status.parity_err;
    assign frame_err  = rx_status.frame_err;

endmodule

// File: verilog/uart_pkg.sv
`include "uart_settings.svh"

package uart_pkg;

    typedef logic [7:0] uart_byte_t;                   // One payload byte

    // Frame in wire order with the start bit in the LSB
    typedef struct packed {
        logic       stop;                              // Always 1 on transmit
        logic       parity;                            // From frame_parity
        uart_byte_t data;                              // LSB goes out first
        logic       start;                             // Always 0 on transmit
    } uart_frame_t;

    // Per byte receive result
    typedef struct packed {
        logic parity_err;                              // Sampled parity mismatch
        logic frame_err;                               // Stop bit seen low
    } rx_status_t;

    // Parity bit for one byte
    function automatic logic frame_parity(input uart_byte_t data);
        logic p;
        p = ^data;                                     // Even parity term
        if (`UART_PARITY_ODD != 0) begin
            p = ~p;                                    // Odd sense
        end
        return p;
    endfunction

endpackage

// File: verilog/uart_rx.sv
module uart_rx (
    input  logic                 baud_clk,
    input  logic                 rst_n,
    input  logic                 rx,                   // Serial line in
    output uart_pkg::uart_byte_t rx_data,              // Valid with rx_valid
    output logic                 rx_valid,             // One cycle per byte
    output uart_pkg::rx_status_t rx_status             // Held until next byte
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP,
        RX_DONE
    } rx_state_t;

    rx_state_t   state;
    logic        rx_q;                                 // Line one cycle back
    logic        fall;                                 // High to low seen
    logic        restart;                              // Align ticks to start
    logic        mid_tick;                             // Sample point
    logic [2:0]  bit_cnt;                              // Data bit index
    uart_frame_t sr;                                   // Samples in wire order

    assign fall    = rx_q && !rx;
    assign restart = (state == RX_IDLE) && fall;

    bit_tick_gen u_tick (
        .baud_clk (baud_clk),
        .rst_n    (rst_n),
        .restart  (restart),
        .mid_tick (mid_tick),
        .end_tick ()
    );

    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            rx_q <= 1'b1;                              // Idle line level
        end else begin
            rx_q <= rx;
        end
    end

    // Samples enter the shift register at the top
    always_ff @(posedge baud_clk) begin
        if (mid_tick && state inside {RX_START, RX_DATA, RX_PARITY, RX_STOP}) begin
            sr <= {rx, sr[$bits(uart_frame_t)-1:1]};
        end
    end

    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
            rx_status <= '0;
        end else begin
            rx_valid <= 1'b0;                          // Strobe by default
            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        state <= RX_START;             // Candidate start bit
                    end
                end
                RX_START: begin
                    if (mid_tick) begin
                        bit_cnt <= '0;
                        // Line back high means a glitch
                        state   <= rx ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (mid_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                end
                RX_PARITY: begin
                    if (mid_tick) begin
                        state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (mid_tick) begin
                        state <= RX_DONE;              // Full frame next cycle
                    end
                end
                RX_DONE: begin
                    rx_valid             <= 1'b1;
                    rx_status.parity_err <= sr.parity != frame_parity(sr.data);
                    rx_status.frame_err  <= !sr.stop;  // Stop must be high
                    state                <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Byte register updates only on completion
    always_ff @(posedge baud_clk) begin
        if (state == RX_DONE) begin
            rx_data <= sr.data;
        end
    end

endmodule

// File: verilog/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Serial bit length in baud_clk cycles
// Must stay even and no smaller than 4
`define UART_CLKS_PER_BIT 8

// Parity sense for both directions
// 0 gives even parity and 1 gives odd parity
`define UART_PARITY_ODD 0

`endif

// File: verilog/uart_tx.sv
module uart_tx (
    input  logic                 baud_clk,
    input  logic                 rst_n,
    input  uart_pkg::uart_byte_t tx_data,              // Captured on accept
    input  logic                 start_tx,             // One cycle request
    output logic                 tx_busy,              // High for the whole frame
    shift_if.ctrl                sh
);
    import uart_pkg::*;

    localparam logic [3:0] LAST_BIT = 4'd10;           // Stop bit index

    logic       accept;                                // Request taken this edge
    logic       end_tick;                              // Bit boundary
    logic [3:0] bit_cnt;                               // Bit on the wire now

    // Requests while busy are dropped
    assign accept = start_tx && !tx_busy;

    // Frame alignment follows accept
    bit_tick_gen u_tick (
        .baud_clk (baud_clk),
        .rst_n    (rst_n),
        .restart  (accept),
        .mid_tick (),
        .end_tick (end_tick)
    );

    // Frame assembly straight from the input byte
    always_comb begin
        sh.frame.start  = 1'b0;
        sh.frame.data   = tx_data;
        sh.frame.parity = frame_parity(tx_data);
        sh.frame.stop   = 1'b1;
    end

    assign sh.load  = accept;                          // Shifter takes the frame
    assign sh.shift = tx_busy && end_tick;             // One bit per boundary

    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            bit_cnt <= '0;
        end else if (accept) begin
            tx_busy <= 1'b1;                           // Start bit on the line now
            bit_cnt <= '0;
        end else if (tx_busy && end_tick) begin
            if (bit_cnt == LAST_BIT) begin
                tx_busy <= 1'b0;                       // Stop bit done
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule
